// File: sysctrl.f
+incdir+verilog
verilog/sysctrl_pkg.sv
verilog/acsi_pkg.sv
verilog/sysctrl_cmd.sv
verilog/acsi_word_fifo.sv
verilog/acsi_dma_port.sv
verilog/sysctrl_top.sv
test/sysctrl_tb.sv

// File: test/sysctrl_tb.sv
// System control testbench
// Random MCU frames against a reference model, and a four-phase
// responder with random ack delay on the disk DMA port

`timescale 1ns/100ps
`default_nettype none

`include "sysctrl_macros.svh"

module sysctrl_tb
  import sysctrl_pkg::*, acsi_pkg::*;
();

  logic          clk = 1'b0;
  logic          reset;
  sysctrl_byte_t mcu_byte;
  logic [1:0]    buttons;
  logic [7:0]    int_in;
  logic [7:0]    acsi_status_byte;
  logic          dma_ack;
  logic [7:0]    data_out;
  logic          int_out_n;
  logic [7:0]    int_ack;
  logic [1:0]    leds;
  logic [23:0]   color;
  sysctrl_cfg_t  cfg;
  logic [3:0]    acsi_status_index;
  acsi_status_t  acsi_stat;
  logic          dma_req;
  acsi_word_t    dma_word;
  logic          acsi_overflow;

  integer       seed = 32'h3b5dd76a;
  int           errors = 0;
  int           checks = 0;
  int           tests = 0;
  int           test_errors;
  int           rx_count;
  logic         hold;
  logic         req_q = 1'b0;
  acsi_word_t   exp_words[$];
  // Reference model registers
  logic [1:0]   m_leds;
  logic [23:0]  m_color;
  sysctrl_cfg_t m_cfg;

  sysctrl_top DUT (.*);

  always #4 clk = ~clk;

  task automatic check(input string name, input logic [23:0] exp, input logic [23:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("%-14s %s, %0d errors", name,
             (errors == test_errors) ? "passed" : "failed", errors - test_errors);
    test_errors = errors;
  endtask

  // One strobe per two cycles with data_out read one cycle after the strobe
  task automatic send_byte(input logic start, input logic [7:0] data, output logic [7:0] rd);
    mcu_byte <= {1'b1, start, data};
    @(posedge clk);
    mcu_byte <= {1'b0, 1'b0, 8'h00};
    @(posedge clk);
    rd = data_out;
  endtask

  // Color bytes travel LSB first
  function automatic logic [7:0] rev8(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) r[i] = b[7 - i];
    return r;
  endfunction

  function automatic logic [7:0] cfg_id_char(input int i);
    case (i)
      0: return CFG_ID_CHIPSET;
      1: return CFG_ID_MEMORY;
      2: return CFG_ID_VIDEO;
      3: return CFG_ID_RESET;
      4: return CFG_ID_SCANLINES;
      5: return CFG_ID_VOLUME;
      6: return CFG_ID_WIDE;
      default: return CFG_ID_WPROT;
    endcase
  endfunction

  function automatic sysctrl_cfg_t cfg_update(input sysctrl_cfg_t c, input logic [7:0] id,
                                              input logic [7:0] v);
    case (id)
      "C": c.chipset = v[1:0];
      "M": c.memory = v[0];
      "V": c.video = v[0];
      "R": c.reset_req = v[1:0];
      "S": c.scanlines = v[1:0];
      "A": c.volume = v[1:0];
      "W": c.wide_screen = v[0];
      "P": c.floppy_wprot = v[1:0];
      default: ;
    endcase
    return c;
  endfunction

  // Command 8 frame of which only the first keep words reach the port
  task automatic disk_frame(input int nwords, input int keep);
    acsi_word_t w;
    logic [7:0] rd;
    send_byte(1'b1, CMD_DISK_DATA, rd);
    for (int i = 0; i < nwords; i++) begin
      w.hi = $random(seed);
      w.lo = $random(seed);
      if (i < keep) exp_words.push_back(w);
      send_byte(1'b0, w.hi, rd);
      send_byte(1'b0, w.lo, rd);
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_words.size() != 0 || dma_req || dma_ack) && n < 500) begin
      @(posedge clk);
      n++;
    end
    if (exp_words.size() != 0 || dma_req || dma_ack) begin
      stop_on_timeout("disk words were not all delivered");
    end
  endtask

  // Four-phase responder with random delay before ack and before release
  always begin : responder
    int delay;
    int n;
    @(posedge clk);
    if (!reset && dma_req && !hold) begin
      delay = $unsigned($random(seed)) % 7;
      repeat (delay) @(posedge clk);
      if (exp_words.size() == 0) begin
        $display("Unexpected disk word %h at %0t ns", dma_word, $time);
        errors++;
      end else begin
        check("dma_word", exp_words.pop_front(), dma_word);
      end
      rx_count++;
      dma_ack <= 1'b1;
      n = 0;
      while (dma_req && n < 100) begin
        @(posedge clk);
        n++;
      end
      if (dma_req) begin
        stop_on_timeout("dma_req did not drop after dma_ack");
      end else begin
        delay = $unsigned($random(seed)) % 7;
        repeat (delay) @(posedge clk);
        dma_ack <= 1'b0;
      end
    end
  end

  // A new request must not start while ack is still high
  always @(posedge clk) begin
    if (!reset && dma_req && !req_q) begin
      checks++;
      assert (!dma_ack) else begin
        $display("dma_req rose at %0t ns while dma_ack was still high", $time);
        errors++;
      end
    end
    req_q <= dma_req;
  end

  initial begin
    logic [7:0] rd;
    logic [7:0] d;
    logic [7:0] id;
    int         r;
    int         n;
    reset = 1'b1;
    mcu_byte = '0;
    buttons = 2'b00;
    int_in = 8'h00;
    acsi_status_byte = 8'h00;
    dma_ack = 1'b0;
    hold = 1'b0;
    rx_count = 0;
    m_leds = '0;
    m_color = '0;
    m_cfg = '0;
    test_errors = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // Reset values, identification and buttons
    check("leds", '0, leds);
    check("color", '0, color);
    check("cfg", '0, cfg);
    check("acsi_stat", '0, acsi_stat);
    check("int_ack", '0, int_ack);
    check("dma_req", '0, dma_req);
    check("acsi_overflow", '0, acsi_overflow);
    send_byte(1'b1, CMD_IDENT, rd);
    send_byte(1'b0, $random(seed), rd);
    check("data_out", `SYSCTRL_ID0, rd);
    send_byte(1'b0, $random(seed), rd);
    check("data_out", `SYSCTRL_ID1, rd);
    send_byte(1'b0, $random(seed), rd);
    check("data_out", `SYSCTRL_CORE_ID, rd);
    for (int i = 0; i < 4; i++) begin
      buttons <= $random(seed);
      send_byte(1'b1, CMD_BUTTONS, rd);
      send_byte(1'b0, $random(seed), rd);
      check("data_out", {6'b000000, buttons}, rd);
    end
    report_test("ident_buttons");

    // LEDs and color with color bytes landing in green, blue, red order
    for (int i = 0; i < 10; i++) begin
      d = $random(seed);
      send_byte(1'b1, CMD_LEDS, rd);
      send_byte(1'b0, d, rd);
      m_leds = d[1:0];
      check("leds", m_leds, leds);
      send_byte(1'b1, CMD_COLOR, rd);
      for (int k = 1; k <= 3; k++) begin
        d = $random(seed);
        send_byte(1'b0, d, rd);
        if (k == 1) m_color[15:8] = rev8(d);
        if (k == 2) m_color[7:0] = rev8(d);
        if (k == 3) m_color[23:16] = rev8(d);
      end
      check("color", m_color, color);
    end
    report_test("leds_color");

    // Valid and unknown config ids
    for (int i = 0; i < 30; i++) begin
      r = $unsigned($random(seed)) % 12;
      id = (r < 8) ? cfg_id_char(r) : 8'h30 + r[7:0];
      d = $random(seed);
      send_byte(1'b1, CMD_CONFIG, rd);
      send_byte(1'b0, id, rd);
      send_byte(1'b0, d, rd);
      m_cfg = cfg_update(m_cfg, id, d);
      check("cfg", m_cfg, cfg);
    end
    report_test("config");

    // Interrupt line, interrupt ack, disk status and ack/nak
    for (int i = 0; i < 8; i++) begin
      int_in <= ($random(seed) & 1) ? $random(seed) : 8'h00;
      @(posedge clk);
      check("int_out_n", (int_in == 8'h00), int_out_n);
      int_in <= $random(seed);
      d = $random(seed);
      send_byte(1'b1, CMD_INT, rd);
      send_byte(1'b0, d, rd);
      check("data_out", int_in, rd);
      check("int_ack", d, int_ack);
      @(posedge clk);
      check("int_ack", 8'h00, int_ack);
      // Status bytes are numbered from zero by data byte position
      send_byte(1'b1, CMD_DISK_STATUS, rd);
      for (int k = 0; k < 3; k++) begin
        check("acsi_status_index", k, acsi_status_index);
        acsi_status_byte <= $random(seed);
        send_byte(1'b0, $random(seed), rd);
        check("data_out", acsi_status_byte, rd);
      end
      d = $random(seed);
      send_byte(1'b1, CMD_DISK_ACK, rd);
      send_byte(1'b0, d, rd);
      check("acsi_stat.ack", d[0], acsi_stat.ack);
      check("acsi_stat.nak", !d[0], acsi_stat.nak);
      @(posedge clk);
      check("acsi_stat.ack", 1'b0, acsi_stat.ack);
      check("acsi_stat.nak", 1'b0, acsi_stat.nak);
      d = $random(seed);
      send_byte(1'b0, d, rd);
      check("acsi_stat.dma_status", d, acsi_stat.dma_status);
    end
    report_test("int_status");

    // At most four words per frame so the buffer never overflows
    for (int i = 0; i < 8; i++) begin
      n = 1 + $unsigned($random(seed)) % 4;
      disk_frame(n, n);
      wait_drained();
    end
    check("acsi_overflow", 1'b0, acsi_overflow);
    report_test("disk_words");

    // Ack withheld so one word waits in the port with a full buffer behind it
    hold <= 1'b1;
    rx_count = 0;
    disk_frame(`SYSCTRL_FIFO_DEPTH + 3, `SYSCTRL_FIFO_DEPTH + 1);
    @(posedge clk);
    check("acsi_overflow", 1'b1, acsi_overflow);
    hold <= 1'b0;
    wait_drained();
    repeat (20) @(posedge clk);
    check("rx_count", `SYSCTRL_FIFO_DEPTH + 1, rx_count);
    report_test("overflow");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/acsi_dma_port.sv
// Disk DMA port
// Takes one word at a time from the disk word buffer and hands
// it to the disk controller with a four-phase req/ack handshake.
// A new word is only started once ack has been seen low again

`timescale 1ns/100ps
`default_nettype none

module acsi_dma_port
  import acsi_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic empty,
  input  acsi_word_t head_word,
  input  wire logic dma_ack,
  output logic      pop,
  output logic      dma_req,
  output acsi_word_t dma_word
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RELEASE
  } port_state_e;

  port_state_e state;

  // Word is taken from the buffer on the edge that raises req
  assign pop = (state == ST_IDLE) && !empty;

  always_ff @(posedge clk) begin
    if (pop) dma_word <= head_word;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      dma_req <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (!empty) begin
            dma_req <= 1'b1;
            state   <= ST_REQ;
          end
        end
        ST_REQ: begin
          // Controller has taken the word
          if (dma_ack) begin
            dma_req <= 1'b0;
            state   <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          // Wait for ack to drop before the next word
          if (!dma_ack) state <= ST_IDLE;
        end
        default: begin
          dma_req <= 1'b0;
          state   <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/acsi_pkg.sv
// Hard disk side types
// Disk data word as sent by the MCU and the disk handshake
// status towards the disk controller

`default_nettype none

package acsi_pkg;

  // Disk data word, high byte arrives first on the link
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } acsi_word_t;

  // Ack and nak are single cycle pulses
  typedef struct packed {
    logic       ack;
    logic       nak;
    logic [7:0] dma_status;
  } acsi_status_t;

endpackage

`default_nettype wire

// File: verilog/acsi_word_fifo.sv
// Disk word buffer
// Small circular FIFO between the command decoder and the DMA
// port. The MCU link cannot be stalled, so a word pushed while
// the buffer is full is lost and a sticky overflow flag is set

`timescale 1ns/100ps
`default_nettype none

`include "sysctrl_macros.svh"

module acsi_word_fifo
  import acsi_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic push,
  input  acsi_word_t push_word,
  input  wire logic pop,
  output acsi_word_t head_word,
  output logic      empty,
  output logic      full,
  output logic      overflow
);

  localparam int DEPTH = `SYSCTRL_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  acsi_word_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign do_push   = push && !full;
  assign do_pop    = pop && !empty;
  assign head_word = mem[rd_ptr];

  // Pointer advance with wrap at the buffer end
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_word;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      // Count only moves when exactly one side is active
      if (do_push && !do_pop) count <= count + 1'b1;
      if (do_pop && !do_push) count <= count - 1'b1;
      // Sticky until reset
      if (push && full) overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sysctrl_cmd.sv
// MCU command decoder
// Runs the command frames from the MCU byte link, holds the LED,
// color, configuration and disk status registers and packs
// disk data bytes into words for the disk word buffer

`timescale 1ns/100ps
`default_nettype none

`include "sysctrl_macros.svh"

module sysctrl_cmd
  import sysctrl_pkg::*, acsi_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          reset,
  input  sysctrl_byte_t      mcu_byte,
  input  wire logic [1:0]    buttons,
  input  wire logic [7:0]    int_in,
  input  wire logic [7:0]    acsi_status_byte,
  output logic [7:0]         data_out,
  output logic [7:0]         int_ack,
  output logic [1:0]         leds,
  output logic [23:0]        color,
  output sysctrl_cfg_t       cfg,
  output logic [3:0]         acsi_status_index,
  output acsi_status_t       acsi_stat,
  output logic               push,
  output acsi_word_t         push_word
);

  sysctrl_cmd_e command;
  logic [3:0]   index;
  logic [7:0]   cfg_id;
  logic         word_half;
  logic [7:0]   data_rev;

  // Color bytes come in LSB first
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      data_rev[i] = mcu_byte.data[7 - i];
    end
  end

  // Status byte selected by position in the command 6 frame
  assign acsi_status_index = index - 4'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      command   <= CMD_IDENT;
      index     <= 4'd0;
      cfg_id    <= 8'h00;
      word_half <= 1'b0;
      int_ack   <= 8'h00;
      leds      <= 2'b00;
      color     <= 24'h000000;
      cfg       <= '0;
      acsi_stat <= '0;
      push      <= 1'b0;
    end else begin
      // Pulses last a single cycle
      int_ack       <= 8'h00;
      acsi_stat.ack <= 1'b0;
      acsi_stat.nak <= 1'b0;
      push          <= 1'b0;

      if (mcu_byte.strobe) begin
        if (mcu_byte.start) begin
          command   <= sysctrl_cmd_e'(mcu_byte.data);
          index     <= 4'd1;
          word_half <= 1'b0;
        end else if (index != 4'd0) begin
          // Index saturates for long frames
          if (index != 4'd15) begin
            index <= index + 4'd1;
          end

          case (command)
            CMD_IDENT: begin
              if (index == 4'd1) data_out <= `SYSCTRL_ID0;
              if (index == 4'd2) data_out <= `SYSCTRL_ID1;
              if (index == 4'd3) data_out <= `SYSCTRL_CORE_ID;
            end
            CMD_LEDS: begin
              if (index == 4'd1) leds <= mcu_byte.data[1:0];
            end
            CMD_COLOR: begin
              // Green, blue, red order as used by the WS2812
              if (index == 4'd1) color[15:8]  <= data_rev;
              if (index == 4'd2) color[7:0]   <= data_rev;
              if (index == 4'd3) color[23:16] <= data_rev;
            end
            CMD_BUTTONS: begin
              data_out <= {6'b000000, buttons};
            end
            CMD_CONFIG: begin
              // Id byte first, then the value
              if (index == 4'd1) cfg_id <= mcu_byte.data;
              if (index == 4'd2) begin
                case (cfg_id)
                  CFG_ID_CHIPSET:   cfg.chipset      <= mcu_byte.data[1:0];
                  CFG_ID_MEMORY:    cfg.memory       <= mcu_byte.data[0];
                  CFG_ID_VIDEO:     cfg.video        <= mcu_byte.data[0];
                  CFG_ID_RESET:     cfg.reset_req    <= mcu_byte.data[1:0];
                  CFG_ID_SCANLINES: cfg.scanlines    <= mcu_byte.data[1:0];
                  CFG_ID_VOLUME:    cfg.volume       <= mcu_byte.data[1:0];
                  CFG_ID_WIDE:      cfg.wide_screen  <= mcu_byte.data[0];
                  CFG_ID_WPROT:     cfg.floppy_wprot <= mcu_byte.data[1:0];
                  default: ;  // Unknown id is ignored
                endcase
              end
            end
            CMD_INT: begin
              // First data byte acknowledges the pending sources
              if (index == 4'd1) int_ack <= mcu_byte.data;
              data_out <= int_in;
            end
            CMD_DISK_STATUS: begin
              data_out <= acsi_status_byte;
            end
            CMD_DISK_ACK: begin
              if (index == 4'd1) begin
                if (mcu_byte.data[0]) acsi_stat.ack <= 1'b1;
                else acsi_stat.nak <= 1'b1;
              end
              if (index == 4'd2) acsi_stat.dma_status <= mcu_byte.data;
            end
            CMD_DISK_DATA: begin
              // High byte first, push once the low byte is in
              if (!word_half) begin
                push_word.hi <= mcu_byte.data;
              end else begin
                push_word.lo <= mcu_byte.data;
                push         <= 1'b1;
              end
              word_half <= ~word_half;
            end
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/sysctrl_macros.svh
// System control parameters
// Disk word buffer depth and the fixed identification bytes
// returned to the MCU by the identification command

`ifndef SYSCTRL_MACROS_SVH
`define SYSCTRL_MACROS_SVH

// Disk words held in the buffer between decoder and DMA port
`define SYSCTRL_FIFO_DEPTH 4

// Pattern that an unprogrammed or absent device would not return
`define SYSCTRL_ID0 8'h5c
`define SYSCTRL_ID1 8'h42

// Core id byte reported after the two pattern bytes
`define SYSCTRL_CORE_ID 8'h01

`endif

// File: verilog/sysctrl_pkg.sv
// System control types
// MCU link byte, command codes, configuration ids and the
// configuration output bundle

`default_nettype none

package sysctrl_pkg;

  // Command byte that opens each MCU frame
  typedef enum logic [7:0] {
    CMD_IDENT       = 8'd0,
    CMD_LEDS        = 8'd1,
    CMD_COLOR       = 8'd2,
    CMD_BUTTONS     = 8'd3,
    CMD_CONFIG      = 8'd4,
    CMD_INT         = 8'd5,
    CMD_DISK_STATUS = 8'd6,
    CMD_DISK_ACK    = 8'd7,
    CMD_DISK_DATA   = 8'd8
  } sysctrl_cmd_e;

  // Configuration variable ids, sent as ASCII characters
  localparam logic [7:0] CFG_ID_CHIPSET   = "C";
  localparam logic [7:0] CFG_ID_MEMORY    = "M";
  localparam logic [7:0] CFG_ID_VIDEO     = "V";
  localparam logic [7:0] CFG_ID_RESET     = "R";
  localparam logic [7:0] CFG_ID_SCANLINES = "S";
  localparam logic [7:0] CFG_ID_VOLUME    = "A";
  localparam logic [7:0] CFG_ID_WIDE      = "W";
  localparam logic [7:0] CFG_ID_WPROT     = "P";

  // One byte from the MCU link
  typedef struct packed {
    logic       strobe;
    logic       start;
    logic [7:0] data;
  } sysctrl_byte_t;

  // User configuration, normally set from the OSD
  typedef struct packed {
    logic [1:0] chipset;      // ST, MegaST or STE
    logic       memory;       // 4MB or 8MB
    logic       video;        // color or mono
    logic [1:0] reset_req;    // run, reset, coldboot
    logic [1:0] scanlines;
    logic [1:0] volume;
    logic       wide_screen;
    logic [1:0] floppy_wprot; // per drive write protect
  } sysctrl_cfg_t;

endpackage

`default_nettype wire

// File: verilog/sysctrl_top.sv
// System control top level
// MCU command decoder feeding disk words through a small buffer
// to the DMA port. Interrupt request to the MCU is active low
// while any interrupt source is pending

`timescale 1ns/100ps
`default_nettype none

module sysctrl_top
  import sysctrl_pkg::*, acsi_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  sysctrl_byte_t   mcu_byte,
  input  wire logic [1:0] buttons,
  input  wire logic [7:0] int_in,
  input  wire logic [7:0] acsi_status_byte,
  input  wire logic       dma_ack,
  output logic [7:0]      data_out,
  output logic            int_out_n,
  output logic [7:0]      int_ack,
  output logic [1:0]      leds,
  output logic [23:0]     color,
  output sysctrl_cfg_t    cfg,
  output logic [3:0]      acsi_status_index,
  output acsi_status_t    acsi_stat,
  output logic            dma_req,
  output acsi_word_t      dma_word,
  output logic            acsi_overflow
);

  logic       push;
  acsi_word_t push_word;
  acsi_word_t head_word;
  logic       empty;
  logic       pop;

  assign int_out_n = ~|int_in;

  sysctrl_cmd u_cmd (
    .clk               (clk),
    .reset             (reset),
    .mcu_byte          (mcu_byte),
    .buttons           (buttons),
    .int_in            (int_in),
    .acsi_status_byte  (acsi_status_byte),
    .data_out          (data_out),
    .int_ack           (int_ack),
    .leds              (leds),
    .color             (color),
    .cfg               (cfg),
    .acsi_status_index (acsi_status_index),
    .acsi_stat         (acsi_stat),
    .push              (push),
    .push_word         (push_word)
  );

  // Full flag stays internal, drops are reported via overflow
  acsi_word_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_word (push_word),
    .pop       (pop),
    .head_word (head_word),
    .empty     (empty),
    .full      (),
    .overflow  (acsi_overflow)
  );

  acsi_dma_port u_dma (
    .clk       (clk),
    .reset     (reset),
    .empty     (empty),
    .head_word (head_word),
    .dma_ack   (dma_ack),
    .pop       (pop),
    .dma_req   (dma_req),
    .dma_word  (dma_word)
  );

endmodule

`default_nettype wire
